// ==== hw/corePkg.sv ====
package corePkg;

    typedef logic [63:0] word_t;
    typedef logic [63:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  creg_addr_t;
    typedef logic [6:0]  opcode_t;

    // base opcodes of the supported subset
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        ADDI,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BEQ,
        LD,
        SW,
        SD,
        ILLEGAL
    } op_t;

    // operand selector codes
    typedef enum logic [1:0] {
        SRCA_REG,
        SRCA_PC,
        SRCA_ZERO
    } srcA_t;

    typedef enum logic [1:0] {
        SRCB_REG,
        SRCB_IMM,
        SRCB_ZERO
    } srcB_t;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_NONE
    } immFmt_t;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        HOLD
    } fetchState_t;

endpackage

// ==== hw/fetchIf.sv ====
`timescale 1ns/1ps

interface fetchIf import corePkg::*; ();

    addr_t pc;
    inst_t instruction;
    logic  valid;
    logic  ready;

    modport producer (
        output pc,
        output instruction,
        output valid,
        input  ready
    );

    modport consumer (
        input  pc,
        input  instruction,
        input  valid,
        output ready
    );

endinterface

// ==== hw/fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import corePkg::*; #(
    parameter addr_t resetPc = '0
) (
    input  logic     clk,
    input  logic     rstN,
    input  logic     fetchEn,
    output addr_t    wbAdr,
    output logic     wbCyc,
    output logic     wbStb,
    input  inst_t    wbDatIn,
    input  logic     wbAck,
    fetchIf.producer fetch
);

    fetchState_t state, stateNext;
    addr_t pc;
    inst_t instReg;

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (fetchEn)
                    stateNext = BUS;
            end
            BUS: begin
                if (wbAck)
                    stateNext = HOLD;
            end
            HOLD: begin
                // next read goes out right after the handoff
                if (fetch.ready)
                    stateNext = fetchEn ? BUS : IDLE;
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            pc    <= resetPc;
        end else begin
            state <= stateNext;
            if (state == HOLD && fetch.ready)
                pc <= pc + 64'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUS && wbAck)
            instReg <= wbDatIn;
    end

    assign wbCyc = (state == BUS);
    assign wbStb = wbCyc;
    assign wbAdr = pc;

    assign fetch.pc          = pc;
    assign fetch.instruction = instReg;
    assign fetch.valid       = (state == HOLD);

endmodule

// ==== hw/decoder.sv ====
`timescale 1ns/1ps

module decoder import corePkg::*; (
    input  inst_t      instruction,
    output op_t        op,
    output immFmt_t    immFmt,
    output srcA_t      srcASel,
    output srcB_t      srcBSel,
    output creg_addr_t rd,
    output logic       regWrite
);

    opcode_t opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign funct7 = instruction[31:25];

    always_comb begin
        op = ILLEGAL;
        case (opcode)
            OPC_OP: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000)
                    op = ADD;
                else if (funct3 == 3'b000 && funct7 == 7'b0100000)
                    op = SUB;
            end
            OPC_OPIMM:  op = (funct3 == 3'b000) ? ADDI : ILLEGAL;
            OPC_LUI:    op = LUI;
            OPC_AUIPC:  op = AUIPC;
            OPC_JAL:    op = JAL;
            OPC_JALR:   op = (funct3 == 3'b000) ? JALR : ILLEGAL;
            OPC_BRANCH: op = (funct3 == 3'b000) ? BEQ : ILLEGAL;
            OPC_LOAD:   op = (funct3 == 3'b011) ? LD : ILLEGAL;
            OPC_STORE: begin
                if (funct3 == 3'b010)
                    op = SW;
                else if (funct3 == 3'b011)
                    op = SD;
            end
            default: op = ILLEGAL;
        endcase
    end

    // control fields follow from the operation alone
    always_comb begin
        immFmt   = IMM_NONE;
        srcASel  = SRCA_ZERO;
        srcBSel  = SRCB_ZERO;
        regWrite = 1'b0;
        case (op)
            ADD, SUB: begin
                srcASel  = SRCA_REG;
                srcBSel  = SRCB_REG;
                regWrite = 1'b1;
            end
            ADDI, LD, JALR: begin
                immFmt   = IMM_I;
                srcASel  = SRCA_REG;
                srcBSel  = SRCB_IMM;
                regWrite = 1'b1;
            end
            SW, SD: begin
                immFmt  = IMM_S;
                srcASel = SRCA_REG;
                srcBSel = SRCB_IMM;
            end
            BEQ: begin
                immFmt  = IMM_B;
                srcASel = SRCA_REG;
                srcBSel = SRCB_REG;
            end
            LUI: begin
                immFmt   = IMM_U;
                srcBSel  = SRCB_IMM;
                regWrite = 1'b1;
            end
            AUIPC: begin
                immFmt   = IMM_U;
                srcASel  = SRCA_PC;
                srcBSel  = SRCB_IMM;
                regWrite = 1'b1;
            end
            JAL: begin
                immFmt   = IMM_J;
                srcASel  = SRCA_PC;
                srcBSel  = SRCB_IMM;
                regWrite = 1'b1;
            end
            default: ;
        endcase
    end

    // rd only reported for ops that write back
    assign rd = regWrite ? instruction[11:7] : '0;

endmodule

// ==== hw/extend.sv ====
`timescale 1ns/1ps

module extend import corePkg::*; (
    input  inst_t   instruction,
    input  immFmt_t immFmt,
    output word_t   imm
);

    logic sign;

    assign sign = instruction[31];

    always_comb begin
        case (immFmt)
            IMM_I: imm = {{52{sign}}, instruction[31:20]};
            IMM_S: imm = {{52{sign}}, instruction[31:25], instruction[11:7]};
            IMM_B: begin
                imm = {{51{sign}}, instruction[31], instruction[7],
                       instruction[30:25], instruction[11:8], 1'b0};
            end
            // upper immediate, sign extended past bit 31 on rv64
            IMM_U: imm = {{32{sign}}, instruction[31:12], 12'b0};
            IMM_J: begin
                imm = {{43{sign}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== hw/operandSelect.sv ====
`timescale 1ns/1ps

module operandSelect import corePkg::*; (
    input  addr_t pc,
    input  word_t rd1,
    input  word_t rd2,
    input  word_t imm,
    input  srcA_t srcASel,
    input  srcB_t srcBSel,
    output word_t srca,
    output word_t srcb
);

    always_comb begin
        case (srcASel)
            SRCA_REG: srca = rd1;
            SRCA_PC:  srca = word_t'(pc);
            default:  srca = '0;
        endcase
    end

    always_comb begin
        case (srcBSel)
            SRCB_REG: srcb = rd2;
            SRCB_IMM: srcb = imm;
            default:  srcb = '0;
        endcase
    end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile import corePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  creg_addr_t ra1,
    input  creg_addr_t ra2,
    output word_t      rd1,
    output word_t      rd2,
    input  logic       rfWe,
    input  creg_addr_t rfWaddr,
    input  word_t      rfWdata
);

    // x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (rfWe && rfWaddr != '0) begin
            regs[rfWaddr] <= rfWdata;
        end
    end

    // no bypass, a write shows up the cycle after
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// ==== hw/decode.sv ====
`timescale 1ns/1ps

module decode import corePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    fetchIf.consumer   fetch,
    output creg_addr_t ra1,
    output creg_addr_t ra2,
    input  word_t      rd1,
    input  word_t      rd2,
    input  logic       decReady,
    output logic       decValid,
    output addr_t      decPc,
    output op_t        decOp,
    output creg_addr_t decRd,
    output logic       decRegWrite,
    output word_t      decSrca,
    output word_t      decSrcb,
    output word_t      decImm,
    output word_t      decMemData,
    output word_t      decPcData
);

    op_t        op;
    immFmt_t    immFmt;
    srcA_t      srcASel;
    srcB_t      srcBSel;
    creg_addr_t rd;
    logic       regWrite;
    word_t      imm;
    word_t      srca, srcb;
    logic       take;

    decoder uDecoder (
        .instruction(fetch.instruction),
        .op(op),
        .immFmt(immFmt),
        .srcASel(srcASel),
        .srcBSel(srcBSel),
        .rd(rd),
        .regWrite(regWrite)
    );

    extend uExtend (
        .instruction(fetch.instruction),
        .immFmt(immFmt),
        .imm(imm)
    );

    operandSelect uOperandSelect (
        .pc(fetch.pc),
        .rd1(rd1),
        .rd2(rd2),
        .imm(imm),
        .srcASel(srcASel),
        .srcBSel(srcBSel),
        .srca(srca),
        .srcb(srcb)
    );

    assign ra1 = fetch.instruction[19:15];
    assign ra2 = fetch.instruction[24:20];

    // accept when the output slot is free or draining this cycle
    assign fetch.ready = !decValid || decReady;
    assign take        = fetch.valid && fetch.ready;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN)
            decValid <= 1'b0;
        else if (take)
            decValid <= 1'b1;
        else if (decReady)
            decValid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            decPc       <= fetch.pc;
            decOp       <= op;
            decRd       <= rd;
            decRegWrite <= regWrite;
            decSrca     <= srca;
            decSrcb     <= srcb;
            decImm      <= imm;
            decMemData  <= (op == SW || op == SD) ? rd2 : '0;
            decPcData   <= (op == JALR) ? rd1 : '0;
        end
    end

endmodule

// ==== hw/frontEnd.sv ====
`timescale 1ns/1ps

module frontEnd import corePkg::*; #(
    parameter addr_t resetPc = '0
) (
    input  logic       clk,
    input  logic       rstN,
    input  logic       fetchEn,
    output addr_t      wbAdr,
    output logic       wbCyc,
    output logic       wbStb,
    input  inst_t      wbDatIn,
    input  logic       wbAck,
    input  logic       rfWe,
    input  creg_addr_t rfWaddr,
    input  word_t      rfWdata,
    input  logic       decReady,
    output logic       decValid,
    output addr_t      decPc,
    output op_t        decOp,
    output creg_addr_t decRd,
    output logic       decRegWrite,
    output word_t      decSrca,
    output word_t      decSrcb,
    output word_t      decImm,
    output word_t      decMemData,
    output word_t      decPcData
);

    creg_addr_t ra1, ra2;
    word_t      rd1, rd2;

    fetchIf fetchBus ();

    fetchUnit #(
        .resetPc(resetPc)
    ) uFetchUnit (
        .clk(clk),
        .rstN(rstN),
        .fetchEn(fetchEn),
        .wbAdr(wbAdr),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbDatIn(wbDatIn),
        .wbAck(wbAck),
        .fetch(fetchBus.producer)
    );

    decode uDecode (
        .clk(clk),
        .rstN(rstN),
        .fetch(fetchBus.consumer),
        .ra1(ra1),
        .ra2(ra2),
        .rd1(rd1),
        .rd2(rd2),
        .decReady(decReady),
        .decValid(decValid),
        .decPc(decPc),
        .decOp(decOp),
        .decRd(decRd),
        .decRegWrite(decRegWrite),
        .decSrca(decSrca),
        .decSrcb(decSrcb),
        .decImm(decImm),
        .decMemData(decMemData),
        .decPcData(decPcData)
    );

    regFile uRegFile (
        .clk(clk),
        .rstN(rstN),
        .ra1(ra1),
        .ra2(ra2),
        .rd1(rd1),
        .rd2(rd2),
        .rfWe(rfWe),
        .rfWaddr(rfWaddr),
        .rfWdata(rfWdata)
    );

endmodule

// ==== sim/frontEnd_chk.sv ====
`timescale 1ns/1ps

module frontEnd_chk import corePkg::*; (
    input logic       clk,
    input logic       rstN,
    input addr_t      wbAdr,
    input logic       wbCyc,
    input logic       wbStb,
    input logic       wbAck,
    input logic       decReady,
    input logic       decValid,
    input addr_t      decPc,
    input op_t        decOp,
    input creg_addr_t decRd,
    input logic       decRegWrite,
    input word_t      decSrca,
    input word_t      decSrcb,
    input word_t      decImm,
    input word_t      decMemData,
    input word_t      decPcData
);

    int failCount = 0;

    // address held until the slave acks
    adrStable: assert property (@(posedge clk) disable iff (!rstN)
        (wbCyc && !wbAck) |=> $stable(wbAdr))
        else begin
            $error("wbAdr changed while waiting for ack");
            failCount++;
        end

    strobeMatch: assert property (@(posedge clk) wbStb == wbCyc)
        else begin
            $error("wbStb differs from wbCyc");
            failCount++;
        end

    // stalled bundle must not move
    decodeHold: assert property (@(posedge clk) disable iff (!rstN)
        (decValid && !decReady) |=> (decValid && $stable(decPc) && $stable(decOp)
            && $stable(decRd) && $stable(decRegWrite)
            && $stable(decSrca) && $stable(decSrcb) && $stable(decImm)
            && $stable(decMemData) && $stable(decPcData)))
        else begin
            $error("decode output changed while stalled");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk)
        !rstN |=> (!wbCyc && !decValid))
        else begin
            $error("wbCyc or decValid high during reset");
            failCount++;
        end

endmodule

// ==== sim/frontEndTb.sv ====
`timescale 1ns/1ps

module frontEndTb import corePkg::*; ();

    localparam addr_t resetPc      = 64'h0000_0000_0000_1000;
    localparam int    numEntries   = 16;
    localparam int    timeoutLimit = numEntries * 12 + 100;

    logic       clk      = 1'b0;
    logic       rstN     = 1'b0;
    logic       fetchEn  = 1'b0;
    inst_t      wbDatIn  = '0;
    logic       wbAck    = 1'b0;
    logic       rfWe     = 1'b0;
    creg_addr_t rfWaddr  = '0;
    word_t      rfWdata  = '0;
    logic       decReady = 1'b0;

    addr_t      wbAdr;
    logic       wbCyc, wbStb, decValid, decRegWrite;
    addr_t      decPc;
    op_t        decOp;
    creg_addr_t decRd;
    word_t      decSrca, decSrcb, decImm, decMemData, decPcData;

    // stimulus and expected bundle per entry
    inst_t      instTable [numEntries];
    op_t        expOp [numEntries];
    creg_addr_t expRd [numEntries];
    logic       expRegWrite [numEntries];
    word_t      expSrca [numEntries];
    word_t      expSrcb [numEntries];
    word_t      expImm [numEntries];
    word_t      expMem [numEntries];
    word_t      expPcData [numEntries];

    logic [31:0] rngState = 32'h3210;
    int          waitLeft = -1;
    addr_t       offset;
    int          errors = 0;
    int          checked = 0;
    int          cycles = 0;

    frontEnd #(
        .resetPc(resetPc)
    ) u_frontEnd (
        .clk(clk), .rstN(rstN), .fetchEn(fetchEn),
        .wbAdr(wbAdr), .wbCyc(wbCyc), .wbStb(wbStb), .wbDatIn(wbDatIn), .wbAck(wbAck),
        .rfWe(rfWe), .rfWaddr(rfWaddr), .rfWdata(rfWdata),
        .decReady(decReady), .decValid(decValid), .decPc(decPc), .decOp(decOp),
        .decRd(decRd), .decRegWrite(decRegWrite), .decSrca(decSrca), .decSrcb(decSrcb),
        .decImm(decImm), .decMemData(decMemData), .decPcData(decPcData)
    );

    bind frontEnd frontEnd_chk uChk (
        .clk(clk),
        .rstN(rstN),
        .wbAdr(wbAdr),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbAck(wbAck),
        .decReady(decReady),
        .decValid(decValid),
        .decPc(decPc),
        .decOp(decOp),
        .decRd(decRd),
        .decRegWrite(decRegWrite),
        .decSrca(decSrca),
        .decSrcb(decSrcb),
        .decImm(decImm),
        .decMemData(decMemData),
        .decPcData(decPcData)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // register k holds k in every byte
    function automatic word_t regVal(input int k);
        return word_t'(k) * 64'h0101_0101_0101_0101;
    endfunction

    function automatic addr_t entryPc(input int i);
        return resetPc + addr_t'(4 * i);
    endfunction

    task automatic addEntry(input int i, input inst_t w, input op_t op, input creg_addr_t rd,
                            input logic rw, input word_t a, input word_t b, input word_t imm,
                            input word_t mem, input word_t pcd);
        instTable[i]   = w;
        expOp[i]       = op;
        expRd[i]       = rd;
        expRegWrite[i] = rw;
        expSrca[i]     = a;
        expSrcb[i]     = b;
        expImm[i]      = imm;
        expMem[i]      = mem;
        expPcData[i]   = pcd;
    endtask

    task automatic loadTable();
        addEntry(0, 32'h002081B3, ADD, 5'd3, 1'b1, regVal(1), regVal(2), '0, '0, '0);
        addEntry(1, 32'h40628233, SUB, 5'd4, 1'b1, regVal(5), regVal(6), '0, '0, '0);
        addEntry(2, 32'hFFB40393, ADDI, 5'd7, 1'b1, regVal(8), 64'hFFFF_FFFF_FFFF_FFFB,
                 64'hFFFF_FFFF_FFFF_FFFB, '0, '0);
        addEntry(3, 32'h123454B7, LUI, 5'd9, 1'b1, '0, 64'h1234_5000, 64'h1234_5000, '0, '0);
        addEntry(4, 32'h80000517, AUIPC, 5'd10, 1'b1, entryPc(4), 64'hFFFF_FFFF_8000_0000,
                 64'hFFFF_FFFF_8000_0000, '0, '0);
        addEntry(5, 32'hFF9FF0EF, JAL, 5'd1, 1'b1, entryPc(5), 64'hFFFF_FFFF_FFFF_FFF8,
                 64'hFFFF_FFFF_FFFF_FFF8, '0, '0);
        addEntry(6, 32'h01058167, JALR, 5'd2, 1'b1, regVal(11), 64'd16, 64'd16, '0,
                 regVal(11));
        addEntry(7, 32'h00D60863, BEQ, 5'd0, 1'b0, regVal(12), regVal(13), 64'd16, '0, '0);
        addEntry(8, 32'h0187B703, LD, 5'd14, 1'b1, regVal(15), 64'd24, 64'd24, '0, '0);
        addEntry(9, 32'hFF08AA23, SW, 5'd0, 1'b0, regVal(17), 64'hFFFF_FFFF_FFFF_FFF4,
                 64'hFFFF_FFFF_FFFF_FFF4, regVal(16), '0);
        addEntry(10, 32'h0329B423, SD, 5'd0, 1'b0, regVal(19), 64'd40, 64'd40, regVal(18), '0);
        addEntry(11, 32'h00000B33, ADD, 5'd22, 1'b1, '0, '0, '0, '0, '0);
        addEntry(12, 32'hFFFFFFFF, ILLEGAL, 5'd0, 1'b0, '0, '0, '0, '0, '0);
        addEntry(13, 32'hFED60EE3, BEQ, 5'd0, 1'b0, regVal(12), regVal(13),
                 64'hFFFF_FFFF_FFFF_FFFC, '0, '0);
        addEntry(14, 32'h7FFF8013, ADDI, 5'd0, 1'b1, regVal(31), 64'h7FF, 64'h7FF, '0, '0);
        addEntry(15, 32'h00001297, AUIPC, 5'd5, 1'b1, entryPc(15), 64'h1000, 64'h1000, '0, '0);
    endtask

    task automatic compareWord(input int i, input string field, input word_t got,
                               input word_t exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: entry %0d %s is %h, expected %h",
                     $time, i, field, got, exp);
        end
    endtask

    task automatic checkEntry(input int i);
        compareWord(i, "pc", decPc, entryPc(i));
        compareWord(i, "op", word_t'(decOp), word_t'(expOp[i]));
        compareWord(i, "rd", word_t'(decRd), word_t'(expRd[i]));
        compareWord(i, "regWrite", word_t'(decRegWrite), word_t'(expRegWrite[i]));
        compareWord(i, "srca", decSrca, expSrca[i]);
        compareWord(i, "srcb", decSrcb, expSrcb[i]);
        compareWord(i, "imm", decImm, expImm[i]);
        compareWord(i, "memData", decMemData, expMem[i]);
        compareWord(i, "pcData", decPcData, expPcData[i]);
        checked++;
    endtask

    // memory slave with random wait states and random decode stalls
    always @(posedge clk) begin
        rngState = xorshift(rngState);
        decReady <= (rngState[1:0] != 2'b00);
        if (!rstN) begin
            wbAck <= 1'b0;
            waitLeft = -1;
        end else if (wbAck) begin
            wbAck <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (waitLeft < 0) begin
                rngState = xorshift(rngState);
                waitLeft = int'(rngState[1:0]);
            end
            if (waitLeft == 0) begin
                offset = (wbAdr - resetPc) >> 2;
                // nops past the end of the table
                wbDatIn <= (offset < 64'(numEntries)) ? instTable[offset[3:0]] : 32'h0000_0013;
                wbAck <= 1'b1;
                waitLeft = -1;
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

    always @(posedge clk) begin
        if (fetchEn)
            cycles <= cycles + 1;
        if (cycles >= timeoutLimit) begin
            $display("timeout: decode output stalled, %0d of %0d entries seen",
                     checked, numEntries);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        loadTable();
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        for (int k = 1; k < 32; k++) begin
            @(posedge clk);
            rfWe    <= 1'b1;
            rfWaddr <= creg_addr_t'(k);
            rfWdata <= regVal(k);
        end
        @(posedge clk);
        rfWe    <= 1'b0;
        fetchEn <= 1'b1;
        // outputs are steady at the falling edge before the accepting edge
        for (int i = 0; i < numEntries; i++) begin
            do begin
                @(negedge clk);
            end while (!(decValid && decReady));
            checkEntry(i);
        end
        $display("errors: %0d, assertion failures: %0d, entries checked: %0d of %0d",
                 errors, u_frontEnd.uChk.failCount, checked, numEntries);
        if (errors == 0 && u_frontEnd.uChk.failCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
hw/corePkg.sv
hw/fetchIf.sv
hw/fetchUnit.sv
hw/decoder.sv
hw/extend.sv
hw/operandSelect.sv
hw/regFile.sv
hw/decode.sv
hw/frontEnd.sv
sim/frontEnd_chk.sv
sim/frontEndTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module frontEndTb -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
    exit 0
fi
exit 1
